/* design/radar_capture_pkg.sv */
package radar_capture_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // sample counter and global timestamp
  parameter int COUNT_W = 32;
  // drain counter, must hold the waveform delay of 19
  parameter int LATENCY_W = 5;
  // one half of a capture record
  parameter int LANE_W = 32;
  parameter int CTRL_W = 32;
  parameter int ROUTE_W = 2;
  parameter int SOURCE_W = 2;

  //////////////////////////////
  // control word fields
  //////////////////////////////

  // lower lane route, bits 1:0
  parameter int CTRL_ROUTE_L_LSB = 0;
  // upper lane route, bits 5:4
  parameter int CTRL_ROUTE_U_LSB = 4;
  // generator source, bits 9:8
  parameter int CTRL_SOURCE_LSB = 8;

  //////////////////////////////
  // types
  //////////////////////////////

  // i in the upper half, q in the lower
  typedef struct packed {
    logic [15:0] i;
    logic [15:0] q;
  } iq_sample_t;

  typedef struct packed {
    iq_sample_t iq;
    logic       valid;
  } adc_sample_t;

  // start and enable toward one generator
  typedef struct packed {
    logic init;
    logic enable;
  } gen_ctrl_t;

  // status back from one generator
  typedef struct packed {
    logic ready;
    logic done;
    logic active;
  } gen_status_t;

  // lane source codes
  typedef enum logic [ROUTE_W-1:0] {
    ROUTE_ADC_IQ     = 2'b00,
    ROUTE_DAC_IQ     = 2'b01,
    ROUTE_ADC_COUNT  = 2'b10,
    ROUTE_GLBL_COUNT = 2'b11
  } route_sel_t;

  // one captured sample, or a counter header on first/last
  typedef struct packed {
    logic [2*LANE_W-1:0] data;
    logic                valid;
    logic                first;
    logic                last;
  } capture_record_t;

endpackage

/* design/source_arbiter.sv */
`timescale 1ns/1ps

module source_arbiter (
  input  logic                                     clk_245_76MHz,
  input  logic                                     cpu_reset,
  input  logic [radar_capture_pkg::SOURCE_W-1:0]   source_field_i,
  input  logic                                     chirp_init_i,
  input  logic                                     chirp_enable_i,
  input  radar_capture_pkg::gen_status_t           dds_status_i,
  input  radar_capture_pkg::gen_status_t           wfrm_status_i,
  output radar_capture_pkg::gen_ctrl_t             dds_ctrl_o,
  output radar_capture_pkg::gen_ctrl_t             wfrm_ctrl_o,
  output radar_capture_pkg::gen_status_t           chirp_status_o,
  output logic                                     wfrm_sel_o
);

  // high while the waveform player owns the tx chain
  logic wfrm_sel;

  //////////////////////////////
  // source select register
  //////////////////////////////

  // waveform player only when both source bits are set
  // anything else falls back to the chirp dds
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wfrm_sel <= 1'b0;
    end else begin
      wfrm_sel <= &source_field_i;
    end
  end

  assign wfrm_sel_o = wfrm_sel;

  //////////////////////////////
  // control steering
  //////////////////////////////

  // start and enable go to the owner only
  always_comb begin
    dds_ctrl_o.init    = chirp_init_i & ~wfrm_sel;
    dds_ctrl_o.enable  = chirp_enable_i & ~wfrm_sel;
    wfrm_ctrl_o.init   = chirp_init_i & wfrm_sel;
    wfrm_ctrl_o.enable = chirp_enable_i & wfrm_sel;
  end

  //////////////////////////////
  // status merge
  //////////////////////////////

  // owner's ready/done/active passed straight back
  // same cycle, no extra register on the status path
  always_comb begin
    if (wfrm_sel) begin
      chirp_status_o = wfrm_status_i;
    end else begin
      chirp_status_o = dds_status_i;
    end
  end

endmodule

/* design/capture_gate.sv */
`timescale 1ns/1ps

module capture_gate #(
  parameter int CHIRP_DELAY = 3,
  parameter int WFRM_DELAY  = 19
) (
  input  logic clk_245_76MHz,
  input  logic cpu_reset,
  input  logic adc_enable_i,
  input  logic chirp_init_i,
  input  logic wfrm_sel_i,
  input  logic adc_valid_i,
  output logic capture_wr_o,
  output logic first_o,
  output logic last_o
);

  typedef logic [radar_capture_pkg::LATENCY_W-1:0] latency_t;

  // drain times in counter width
  localparam latency_t CHIRP_LOAD = latency_t'(CHIRP_DELAY);
  localparam latency_t WFRM_LOAD  = latency_t'(WFRM_DELAY);

  logic     enable_d;
  logic     capture_on;
  logic     first_q;
  latency_t latency_cnt;
  latency_t latency_load;
  logic     latency_zero;
  logic     enable_fall;

  //////////////////////////////
  // enable sync
  //////////////////////////////

  // one register stage on the enable level
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      enable_d <= 1'b0;
    end else begin
      enable_d <= adc_enable_i;
    end
  end

  // falling edge seen between the raw and delayed enable
  assign enable_fall = enable_d & ~adc_enable_i;

  //////////////////////////////
  // latency counter
  //////////////////////////////

  // waveform path has the longer pipe to drain
  assign latency_load = wfrm_sel_i ? WFRM_LOAD : CHIRP_LOAD;
  assign latency_zero = (latency_cnt == '0);

  // reload on init or on enable fall, else count down and park at zero
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      latency_cnt <= '0;
    end else if (chirp_init_i || enable_fall) begin
      latency_cnt <= latency_load;
    end else if (!latency_zero) begin
      latency_cnt <= latency_cnt - 1'b1;
    end
  end

  //////////////////////////////
  // capture level and markers
  //////////////////////////////

  // capture level follows enable only once the drain is over
  // so it opens at once but closes late
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      capture_on <= 1'b0;
      first_q    <= 1'b0;
    end else begin
      if (latency_zero) begin
        capture_on <= enable_d;
      end
      // single cycle marker on the opening edge
      first_q <= latency_zero & enable_d & ~capture_on;
    end
  end

  assign first_o = first_q;

  // final record, capture still open but enable already gone
  assign last_o = latency_zero & capture_on & ~enable_d;

  // one record per valid adc sample while open
  assign capture_wr_o = capture_on & adc_valid_i;

endmodule

/* design/sample_counters.sv */
`timescale 1ns/1ps

module sample_counters (
  input  logic                                   clk_245_76MHz,
  input  logic                                   cpu_reset,
  input  logic                                   capture_wr_i,
  output logic [radar_capture_pkg::COUNT_W-1:0]  adc_count_o,
  output logic [radar_capture_pkg::COUNT_W-1:0]  glbl_count_o
);

  logic [radar_capture_pkg::COUNT_W-1:0] adc_count;
  logic [radar_capture_pkg::COUNT_W-1:0] glbl_count;

  //////////////////////////////
  // global timestamp
  //////////////////////////////

  // free running, wraps silently
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      glbl_count <= '0;
    end else begin
      glbl_count <= glbl_count + 1'b1;
    end
  end

  //////////////////////////////
  // captured samples
  //////////////////////////////

  // counts every written record, headers included
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      adc_count <= '0;
    end else if (capture_wr_i) begin
      adc_count <= adc_count + 1'b1;
    end
  end

  assign adc_count_o  = adc_count;
  assign glbl_count_o = glbl_count;

endmodule

/* design/record_assembler.sv */
`timescale 1ns/1ps

module record_assembler (
  input  logic                                   clk_245_76MHz,
  input  logic                                   cpu_reset,
  input  radar_capture_pkg::route_sel_t          route_field_u_i,
  input  radar_capture_pkg::route_sel_t          route_field_l_i,
  input  radar_capture_pkg::iq_sample_t          adc_iq_i,
  input  radar_capture_pkg::iq_sample_t          dac_iq_i,
  input  logic [radar_capture_pkg::COUNT_W-1:0]  adc_count_i,
  input  logic [radar_capture_pkg::COUNT_W-1:0]  glbl_count_i,
  input  logic                                   capture_wr_i,
  input  logic                                   first_i,
  input  logic                                   last_i,
  output radar_capture_pkg::capture_record_t     record_o
);

  typedef logic [radar_capture_pkg::LANE_W-1:0] lane_t;

  radar_capture_pkg::route_sel_t route_u;
  radar_capture_pkg::route_sel_t route_l;
  lane_t                         lane_u;
  lane_t                         lane_l;

  // four way lane mux, shared by both lanes
  function automatic lane_t lane_select(
    input radar_capture_pkg::route_sel_t sel,
    input lane_t                         adc_iq,
    input lane_t                         dac_iq,
    input lane_t                         adc_count,
    input lane_t                         glbl_count
  );
    lane_t lane;
    lane = adc_iq;
    case (sel)
      radar_capture_pkg::ROUTE_DAC_IQ:     lane = dac_iq;
      radar_capture_pkg::ROUTE_ADC_COUNT:  lane = adc_count;
      radar_capture_pkg::ROUTE_GLBL_COUNT: lane = glbl_count;
      default:                             lane = adc_iq;
    endcase
    return lane;
  endfunction

  //////////////////////////////
  // route registers
  //////////////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      route_u <= radar_capture_pkg::ROUTE_ADC_IQ;
      route_l <= radar_capture_pkg::ROUTE_ADC_IQ;
    end else begin
      route_u <= route_field_u_i;
      route_l <= route_field_l_i;
    end
  end

  //////////////////////////////
  // record build
  //////////////////////////////

  assign lane_u = lane_select(route_u, adc_iq_i, dac_iq_i, adc_count_i, glbl_count_i);
  assign lane_l = lane_select(route_l, adc_iq_i, dac_iq_i, adc_count_i, glbl_count_i);

  // header of both counters replaces the data on first and last
  always_comb begin
    record_o.valid = capture_wr_i;
    record_o.first = first_i;
    record_o.last  = last_i;
    if (first_i || last_i) begin
      record_o.data = {glbl_count_i, adc_count_i};
    end else begin
      record_o.data = {lane_u, lane_l};
    end
  end

endmodule

/* design/radar_capture_top.sv */
`timescale 1ns/1ps

module radar_capture_top #(
  parameter int CHIRP_DELAY = 3,
  parameter int WFRM_DELAY  = 19
) (
  input  logic                                  clk_245_76MHz,
  input  logic                                  cpu_reset,
  input  logic [radar_capture_pkg::CTRL_W-1:0]  chirp_control_word_i,
  input  logic                                  chirp_init_i,
  input  logic                                  chirp_enable_i,
  input  logic                                  adc_enable_i,
  input  radar_capture_pkg::adc_sample_t        adc_i,
  input  radar_capture_pkg::iq_sample_t         dac_iq_i,
  input  radar_capture_pkg::gen_status_t        dds_status_i,
  input  radar_capture_pkg::gen_status_t        wfrm_status_i,
  output radar_capture_pkg::gen_ctrl_t          dds_ctrl_o,
  output radar_capture_pkg::gen_ctrl_t          wfrm_ctrl_o,
  output radar_capture_pkg::gen_status_t        chirp_status_o,
  output radar_capture_pkg::capture_record_t    record_o
);

  //////////////////////////////
  // control word fields
  //////////////////////////////

  logic [radar_capture_pkg::SOURCE_W-1:0] source_field;
  radar_capture_pkg::route_sel_t          route_field_u;
  radar_capture_pkg::route_sel_t          route_field_l;

  // bits 9:8 source, 5:4 upper lane, 1:0 lower lane
  assign source_field = chirp_control_word_i[radar_capture_pkg::CTRL_SOURCE_LSB
                                             +: radar_capture_pkg::SOURCE_W];
  assign route_field_u = radar_capture_pkg::route_sel_t'(
    chirp_control_word_i[radar_capture_pkg::CTRL_ROUTE_U_LSB +: radar_capture_pkg::ROUTE_W]);
  assign route_field_l = radar_capture_pkg::route_sel_t'(
    chirp_control_word_i[radar_capture_pkg::CTRL_ROUTE_L_LSB +: radar_capture_pkg::ROUTE_W]);

  // block to block wires
  logic                                  wfrm_sel;
  logic                                  capture_wr;
  logic                                  first;
  logic                                  last;
  logic [radar_capture_pkg::COUNT_W-1:0] adc_count;
  logic [radar_capture_pkg::COUNT_W-1:0] glbl_count;

  //////////////////////////////
  // generator steering
  //////////////////////////////

  source_arbiter source_arbiter_i (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .source_field_i (source_field),
    .chirp_init_i   (chirp_init_i),
    .chirp_enable_i (chirp_enable_i),
    .dds_status_i   (dds_status_i),
    .wfrm_status_i  (wfrm_status_i),
    .dds_ctrl_o     (dds_ctrl_o),
    .wfrm_ctrl_o    (wfrm_ctrl_o),
    .chirp_status_o (chirp_status_o),
    .wfrm_sel_o     (wfrm_sel)
  );

  //////////////////////////////
  // capture window
  //////////////////////////////

  // drain time picked from the active source
  capture_gate #(
    .CHIRP_DELAY (CHIRP_DELAY),
    .WFRM_DELAY  (WFRM_DELAY)
  ) capture_gate_i (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .adc_enable_i  (adc_enable_i),
    .chirp_init_i  (chirp_init_i),
    .wfrm_sel_i    (wfrm_sel),
    .adc_valid_i   (adc_i.valid),
    .capture_wr_o  (capture_wr),
    .first_o       (first),
    .last_o        (last)
  );

  //////////////////////////////
  // counters and record
  //////////////////////////////

  sample_counters sample_counters_i (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .capture_wr_i  (capture_wr),
    .adc_count_o   (adc_count),
    .glbl_count_o  (glbl_count)
  );

  // record leaves as a bare strobe, no ready
  record_assembler record_assembler_i (
    .clk_245_76MHz   (clk_245_76MHz),
    .cpu_reset       (cpu_reset),
    .route_field_u_i (route_field_u),
    .route_field_l_i (route_field_l),
    .adc_iq_i        (adc_i.iq),
    .dac_iq_i        (dac_iq_i),
    .adc_count_i     (adc_count),
    .glbl_count_i    (glbl_count),
    .capture_wr_i    (capture_wr),
    .first_i         (first),
    .last_i          (last),
    .record_o        (record_o)
  );

endmodule

/* tb/radar_capture_model.svh */
`ifndef RADAR_CAPTURE_MODEL_SVH
`define RADAR_CAPTURE_MODEL_SVH

//////////////////////////////
// reference model state
//////////////////////////////

// mirrors the registers of the capture core
logic        m_wfrm_sel;
logic        m_enable_d;
int          m_latency;
logic        m_capture_on;
logic        m_first;
logic [31:0] m_glbl;
logic [31:0] m_adc;
logic [1:0]  m_route_u;
logic [1:0]  m_route_l;

// lane source by route code
// 0 adc iq, 1 dac iq, 2 sample count, 3 global count
function automatic logic [31:0] lane_value(input logic [1:0] code);
  logic [31:0] lane;
  case (code)
    2'd0:    lane = adc.iq;
    2'd1:    lane = dac_iq;
    2'd2:    lane = m_adc;
    default: lane = m_glbl;
  endcase
  return lane;
endfunction

// one rising edge, using the inputs held just before it
task automatic model_step();
  logic lat_zero;
  int   load;
  lat_zero = (m_latency == 0);
  load = m_wfrm_sel ? WFRM_DELAY : CHIRP_DELAY;
  if (cpu_reset) begin
    m_wfrm_sel   = 1'b0;
    m_enable_d   = 1'b0;
    m_latency    = 0;
    m_capture_on = 1'b0;
    m_first      = 1'b0;
    m_glbl       = '0;
    m_adc        = '0;
    m_route_u    = 2'd0;
    m_route_l    = 2'd0;
  end else begin
    // everything below reads the old state before it changes
    m_adc = m_adc + (m_capture_on & adc.valid);
    m_first = lat_zero & m_enable_d & ~m_capture_on;
    if (lat_zero) begin
      m_capture_on = m_enable_d;
    end
    // reload on init or on enable fall
    if (chirp_init || (m_enable_d && !adc_enable)) begin
      m_latency = load;
    end else if (!lat_zero) begin
      m_latency = m_latency - 1;
    end
    m_enable_d = adc_enable;
    m_wfrm_sel = control_word[9] & control_word[8];
    m_route_u  = control_word[5:4];
    m_route_l  = control_word[1:0];
    m_glbl     = m_glbl + 1;
  end
endtask

// outputs expected between edges
task automatic model_outputs(
  output radar_capture_pkg::gen_ctrl_t       exp_dds,
  output radar_capture_pkg::gen_ctrl_t       exp_wfrm,
  output radar_capture_pkg::gen_status_t     exp_status,
  output radar_capture_pkg::capture_record_t exp_rec
);
  logic last;
  exp_dds.init    = chirp_init & ~m_wfrm_sel;
  exp_dds.enable  = chirp_enable & ~m_wfrm_sel;
  exp_wfrm.init   = chirp_init & m_wfrm_sel;
  exp_wfrm.enable = chirp_enable & m_wfrm_sel;
  exp_status      = m_wfrm_sel ? wfrm_status : dds_status;
  last = (m_latency == 0) & m_capture_on & ~m_enable_d;
  exp_rec.valid = m_capture_on & adc.valid;
  exp_rec.first = m_first;
  exp_rec.last  = last;
  // header of both counters on first and last
  if (m_first || last) begin
    exp_rec.data = {m_glbl, m_adc};
  end else begin
    exp_rec.data = {lane_value(m_route_u), lane_value(m_route_l)};
  end
endtask

`endif

/* tb/radar_capture_tb.sv */
`timescale 1ns/1ps

module radar_capture_tb;

  localparam int CHIRP_DELAY = 3;
  localparam int WFRM_DELAY  = 19;
  localparam int ROWS        = 8;
  // idle cycles at the end so the last drain finishes
  localparam int TAIL        = WFRM_DELAY + 4;

  // one stimulus row
  typedef struct packed {
    logic [31:0] ctrl;
    logic [7:0]  n_high;
    logic [7:0]  n_low;
    logic        init;
    logic [2:0]  dds_st;
    logic [2:0]  wfrm_st;
  } stim_row_t;

  logic                               clk_245_76MHz;
  logic                               cpu_reset;
  logic [31:0]                        control_word;
  logic                               chirp_init;
  logic                               chirp_enable;
  logic                               adc_enable;
  radar_capture_pkg::adc_sample_t     adc;
  radar_capture_pkg::iq_sample_t      dac_iq;
  radar_capture_pkg::gen_status_t     dds_status;
  radar_capture_pkg::gen_status_t     wfrm_status;
  radar_capture_pkg::gen_ctrl_t       dds_ctrl;
  radar_capture_pkg::gen_ctrl_t       wfrm_ctrl;
  radar_capture_pkg::gen_status_t     chirp_status;
  radar_capture_pkg::capture_record_t rec_out;

  stim_row_t   stim_rows [ROWS];
  logic [31:0] rng_state;
  int          cycle_count;
  int          cycle_limit;
  int          checks;
  int          errors;

  `include "radar_capture_model.svh"

  radar_capture_top #(
    .CHIRP_DELAY (CHIRP_DELAY),
    .WFRM_DELAY  (WFRM_DELAY)
  ) radar_capture_top_i (
    .clk_245_76MHz        (clk_245_76MHz),
    .cpu_reset            (cpu_reset),
    .chirp_control_word_i (control_word),
    .chirp_init_i         (chirp_init),
    .chirp_enable_i       (chirp_enable),
    .adc_enable_i         (adc_enable),
    .adc_i                (adc),
    .dac_iq_i             (dac_iq),
    .dds_status_i         (dds_status),
    .wfrm_status_i        (wfrm_status),
    .dds_ctrl_o           (dds_ctrl),
    .wfrm_ctrl_o          (wfrm_ctrl),
    .chirp_status_o       (chirp_status),
    .record_o             (rec_out)
  );

  // 4 ns period
  always #2 clk_245_76MHz = ~clk_245_76MHz;

  // watchdog on total cycles
  always @(posedge clk_245_76MHz) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  //////////////////////////////
  // one clock of stimulus and checks
  //////////////////////////////

  task automatic apply_cycle(input logic rst, input logic [31:0] ctrl, input logic init,
                             input logic chirp_en, input logic adc_en,
                             input logic [2:0] dds_st, input logic [2:0] wfrm_st);
    radar_capture_pkg::capture_record_t exp_rec;
    radar_capture_pkg::gen_ctrl_t       exp_dds;
    radar_capture_pkg::gen_ctrl_t       exp_wfrm;
    radar_capture_pkg::gen_status_t     exp_status;
    logic [31:0]                        r_valid;
    logic [31:0]                        r_iq;
    @(posedge clk_245_76MHz);
    // model sees the same inputs the dut just sampled
    model_step();
    rng_state = xorshift32(rng_state);
    r_valid = rng_state;
    rng_state = xorshift32(rng_state);
    r_iq = rng_state;
    rng_state = xorshift32(rng_state);
    cpu_reset    <= rst;
    control_word <= ctrl;
    chirp_init   <= init;
    chirp_enable <= chirp_en;
    adc_enable   <= adc_en;
    // roughly three in four samples valid
    adc          <= {r_iq, r_valid[0] | r_valid[1]};
    dac_iq       <= rng_state;
    dds_status   <= dds_st;
    wfrm_status  <= wfrm_st;
    // compare mid cycle, away from the edge
    @(negedge clk_245_76MHz);
    model_outputs(exp_dds, exp_wfrm, exp_status, exp_rec);
    checks = checks + 4;
    if (dds_ctrl !== exp_dds) begin
      errors = errors + 1;
      $display("FAIL dds_ctrl_o got %h expected %h cycle %0d", dds_ctrl, exp_dds, cycle_count);
    end
    if (wfrm_ctrl !== exp_wfrm) begin
      errors = errors + 1;
      $display("FAIL wfrm_ctrl_o got %h expected %h cycle %0d", wfrm_ctrl, exp_wfrm,
               cycle_count);
    end
    if (chirp_status !== exp_status) begin
      errors = errors + 1;
      $display("FAIL chirp_status_o got %h expected %h cycle %0d", chirp_status, exp_status,
               cycle_count);
    end
    if (rec_out !== exp_rec) begin
      errors = errors + 1;
      $display("FAIL record_o got %h expected %h cycle %0d", rec_out, exp_rec, cycle_count);
    end
  endtask

  // enable high phase then drain phase, init pulsed mid drain
  task automatic apply_row(input stim_row_t row);
    int i;
    for (i = 0; i < row.n_high; i++) begin
      apply_cycle(1'b0, row.ctrl, 1'b0, 1'b1, 1'b1, row.dds_st, row.wfrm_st);
    end
    for (i = 0; i < row.n_low; i++) begin
      apply_cycle(1'b0, row.ctrl, row.init && i == 2, 1'b0, 1'b0, row.dds_st, row.wfrm_st);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int r;
    clk_245_76MHz = 1'b0;
    cpu_reset     = 1'b1;
    control_word  = '0;
    chirp_init    = 1'b0;
    chirp_enable  = 1'b0;
    adc_enable    = 1'b0;
    adc           = '0;
    dac_iq        = '0;
    dds_status    = '0;
    wfrm_status   = '0;
    rng_state     = 32'h3731bf2b;
    cycle_count   = 0;
    cycle_limit   = 0;
    checks        = 0;
    errors        = 0;
    // ctrl word, high cycles, low cycles, init, dds status, wfrm status
    // source bits 9:8, upper route 5:4, lower route 1:0
    stim_rows[0] = {32'h0000_0000, 8'd8,  8'd8,  1'b0, 3'b001, 3'b110};
    stim_rows[1] = {32'h0000_0311, 8'd10, 8'd24, 1'b0, 3'b010, 3'b101};
    stim_rows[2] = {32'h0000_0123, 8'd6,  8'd10, 1'b1, 3'b100, 3'b011};
    stim_rows[3] = {32'h0000_0332, 8'd12, 8'd26, 1'b1, 3'b011, 3'b100};
    stim_rows[4] = {32'h0000_0230, 8'd5,  8'd8,  1'b0, 3'b111, 3'b000};
    stim_rows[5] = {32'h0000_0302, 8'd9,  8'd24, 1'b0, 3'b000, 3'b111};
    stim_rows[6] = {32'h0000_0013, 8'd7,  8'd8,  1'b1, 3'b101, 3'b010};
    stim_rows[7] = {32'h0000_0321, 8'd11, 8'd24, 1'b1, 3'b110, 3'b001};
    // reset, tail and margin, then every row plus a full drain
    cycle_limit = 2 + TAIL + 50;
    for (r = 0; r < ROWS; r++) begin
      cycle_limit = cycle_limit + stim_rows[r].n_high + stim_rows[r].n_low + WFRM_DELAY;
    end
    // two edges with reset high
    apply_cycle(1'b1, '0, 1'b0, 1'b0, 1'b0, 3'b000, 3'b000);
    apply_cycle(1'b0, '0, 1'b0, 1'b0, 1'b0, 3'b000, 3'b000);
    for (r = 0; r < ROWS; r++) begin
      apply_row(stim_rows[r]);
    end
    for (r = 0; r < TAIL; r++) begin
      apply_cycle(1'b0, '0, 1'b0, 1'b0, 1'b0, 3'b000, 3'b000);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+tb
design/radar_capture_pkg.sv
design/source_arbiter.sv
design/capture_gate.sv
design/sample_counters.sv
design/record_assembler.sv
design/radar_capture_top.sv
tb/radar_capture_tb.sv
